// ==== compile.f ====
rtl/reg_map_pkg.sv
rtl/osd_pkg.sv
rtl/osd_reg_file.sv
rtl/osd_ram_bank.sv
rtl/osd_char_reader.sv
rtl/osd_subsystem_top.sv
test/osd_subsystem_sva.sv
test/osd_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the OSD subsystem testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module osd_subsystem_tb

# the log decides the verdict, so a nonzero exit from the run is tolerated here
./obj_dir/Vosd_subsystem_tb +verilator+error+limit+100000 > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    exit 1
fi
if ! grep -q '\*\* PASS \*\*' sim.log; then
    echo "simulation ended without a verdict"
    exit 1
fi

// ==== test/osd_subsystem_tb.sv ====
// testbench for the OSD subsystem top level
// drives host writes, reads and display reads, the bound checker does
// the value checks and this module reports per test and the verdict

`timescale 1ns/10ps

module osd_subsystem_tb;
    import reg_map_pkg::*;
    import osd_pkg::*;

    // rough cycle cost per test, reset first
    localparam int TEST_CYCLES = 4 + 90 + 48 + 32 + 12 + 70;
    localparam int CYCLE_LIMIT = TEST_CYCLES + 200;

    logic              clk;
    logic              arst_n;
    logic [7:0]        addr;
    logic [7:0]        wr_data;
    logic              write_en;
    logic [7:0]        rd_data;
    logic [CTRL_W-1:0] ctrl_buttons;
    logic              enable_osd;
    logic [7:0]        highlight_line;
    logic [7:0]        reconf_data;
    video_mode_e       video_mode;
    logic [8:0]        scan_intensity;
    logic              scan_thickness;
    logic              scan_oddeven;
    logic              scan_active;
    logic              reset_dc;
    logic              reset_opt;
    logic [7:0]        reset_conf;
    logic [9:0]        osd_rd_addr;
    logic [7:0]        osd_char;
    logic              osd_highlight;

    logic [31:0] seed = 32'd70;
    int          cycles = 0;
    int          tests_run = 0;
    int          fails_seen = 0;
    logic [6:0]  cols [8];

    osd_subsystem_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout, run went past %0d cycles", CYCLE_LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    // lcg, bits 23..16 are the useful ones
    function automatic logic [7:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[23:16];
    endfunction

    task automatic write_reg(input logic [7:0] a, input logic [7:0] d);
        @(posedge clk);
        addr <= a;
        wr_data <= d;
        write_en <= 1'b1;
        @(posedge clk);
        write_en <= 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] a);
        @(posedge clk);
        addr <= a;
        write_en <= 1'b0;
    endtask

    task automatic hold_write(input logic [7:0] a, input int n);
        @(posedge clk);
        addr <= a;
        write_en <= 1'b1;
        repeat (n) @(posedge clk);
        write_en <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    // waits out the display read latency before counting
    task automatic report_test(input string name);
        int now_fails;
        repeat (4) @(posedge clk);
        now_fails = dut_i.sva_i.err_count;
        tests_run = tests_run + 1;
        $display("test %0d %s: %0d failed checks", tests_run, name, now_fails - fails_seen);
        fails_seen = now_fails;
    endtask

    initial begin
        arst_n = 1'b0;
        addr = 8'h00;
        wr_data = 8'h00;
        write_en = 1'b0;
        ctrl_buttons = '0;
        osd_rd_addr = '0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        report_test("reset values");

        for (int i = 0; i < 6; i++) begin
            write_reg(REG_OSD_ENABLE, next_rand());
            write_reg(REG_HIGHLIGHT, next_rand());
            write_reg(REG_RESET_CONF, next_rand());
            write_reg(REG_SCAN_HI, next_rand());
            write_reg(REG_SCAN_LO, next_rand());
            read_reg(REG_OSD_ENABLE);
            read_reg(REG_HIGHLIGHT);
            read_reg(REG_RESET_CONF);
            read_reg(REG_SCAN_HI);
            read_reg(REG_SCAN_LO);
        end
        report_test("config registers");

        // every low nibble, both mapped and ignored codes
        for (int code = 0; code < 16; code++) begin
            write_reg(REG_RECONF, {next_rand() & 8'hF0} | 8'(code));
            read_reg(REG_RECONF);
        end
        report_test("reconfiguration");

        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            ctrl_buttons <= 12'({next_rand(), next_rand()});
            read_reg(REG_CTRL_HI);
            read_reg(REG_CTRL_LO);
        end
        report_test("controller readback");

        hold_write(REG_RESET_DC, 3);
        hold_write(REG_RESET_OPT, 2);
        report_test("reset levels");

        write_reg(REG_OSD_ENABLE, 8'h01);
        write_reg(REG_HIGHLIGHT, next_rand() & 8'h07);
        for (int k = 0; k < 8; k++) begin
            cols[k] = 7'(next_rand());
            write_reg(REG_OSD_OFFSET, 8'(k));
            write_reg({1'b0, cols[k]}, next_rand());
        end
        repeat (2) @(posedge clk);
        for (int k = 0; k < 8; k++) begin
            @(posedge clk);
            osd_rd_addr <= {3'(k), cols[k]};
        end
        repeat (3) @(posedge clk);
        // same cells again with the OSD switched off
        write_reg(REG_OSD_ENABLE, 8'h00);
        for (int k = 0; k < 8; k++) begin
            @(posedge clk);
            osd_rd_addr <= {3'(k), cols[k]};
        end
        report_test("osd path");

        $display("%0d tests run, %0d failed checks", tests_run, fails_seen);
        if (fails_seen == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== test/osd_subsystem_sva.sv ====
// bound checker for the OSD subsystem top level
// rebuilds the register map and character memory from host traffic
// and compares every output against that model, counting failures

`timescale 1ns/10ps

module osd_subsystem_sva (
    input logic                                     clk,
    input logic                                     arst_n,
    input logic [7:0]                               addr,
    input logic [7:0]                               wr_data,
    input logic                                     write_en,
    input logic [reg_map_pkg::CTRL_W-1:0]           ctrl_buttons,
    input logic [7:0]                               rd_data,
    input logic                                     enable_osd,
    input logic [7:0]                               highlight_line,
    input logic [7:0]                               reconf_data,
    input reg_map_pkg::video_mode_e                 video_mode,
    input logic [reg_map_pkg::SCAN_INTENSITY_W-1:0] scan_intensity,
    input logic                                     scan_thickness,
    input logic                                     scan_oddeven,
    input logic                                     scan_active,
    input logic                                     reset_dc,
    input logic                                     reset_opt,
    input logic [7:0]                               reset_conf,
    input logic [osd_pkg::OSD_BANKS-1:0]            bank_wr_en,
    input logic [osd_pkg::OSD_ADDR_W-1:0]           osd_rd_addr,
    input logic [7:0]                               osd_char,
    input logic                                     osd_highlight
);
    import reg_map_pkg::*;
    import osd_pkg::*;

    int err_count = 0;

    // host bus one edge late
    logic        we_q;
    logic [7:0]  addr_q;
    logic [7:0]  data_q;
    logic [11:0] ctrl_q;
    logic        first_q;

    // register model built from host writes
    logic        en_m;
    logic [7:0]  hl_m;
    logic [7:0]  reconf_m;
    video_mode_e vm_m;
    logic [7:0]  scan_hi_m;
    logic [3:0]  scan_lo_m;
    logic [7:0]  rst_conf_m;

    // bank offset and character memory model
    logic [2:0]  offset_m;
    logic [7:0]  exp_bank;
    logic [7:0]  shadow [1024];
    logic [1023:0] written;

    // display read pipeline
    logic [7:0]  exp1;
    logic [7:0]  exp2;
    logic [2:0]  bank1;
    logic        ev1;
    logic        ev2;
    logic        hl2;

    logic [7:0]  exp_rd;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            we_q <= 1'b0;
            addr_q <= '0;
            data_q <= '0;
            ctrl_q <= '0;
            first_q <= 1'b1;
            en_m <= 1'b0;
            hl_m <= HIGHLIGHT_RST;
            reconf_m <= '0;
            vm_m <= VM_1080P;
            scan_hi_m <= SCAN_INTENSITY_RST[8:1];
            scan_lo_m <= {SCAN_INTENSITY_RST[0], 3'b000};
            rst_conf_m <= '0;
            offset_m <= '0;
            exp_bank <= '0;
            written <= '0;
            exp1 <= '0;
            exp2 <= '0;
            bank1 <= '0;
            ev1 <= 1'b0;
            ev2 <= 1'b0;
            hl2 <= 1'b0;
        end else begin
            we_q <= write_en;
            addr_q <= addr;
            data_q <= wr_data;
            ctrl_q <= ctrl_buttons;
            first_q <= 1'b0;
            if (write_en) begin
                case (addr)
                    REG_OSD_OFFSET: offset_m <= wr_data[2:0];
                    REG_OSD_ENABLE: en_m <= wr_data[0];
                    REG_HIGHLIGHT:  hl_m <= wr_data;
                    REG_RECONF: begin
                        reconf_m <= wr_data;
                        // codes 4..15 keep the old mode
                        if (wr_data[3:0] < 4'd4) begin
                            vm_m <= video_mode_e'(wr_data[1:0]);
                        end
                    end
                    REG_SCAN_HI:    scan_hi_m <= wr_data;
                    REG_SCAN_LO:    scan_lo_m <= wr_data[7:4];
                    REG_RESET_CONF: rst_conf_m <= wr_data;
                    default: ;
                endcase
            end
            // strobe follows the write by one edge
            exp_bank <= (write_en && !addr[7]) ? (8'd1 << offset_m) : 8'd0;
            if (write_en && !addr[7]) begin
                written[{offset_m, addr[6:0]}] <= 1'b1;
            end
            exp1 <= shadow[osd_rd_addr];
            ev1 <= written[osd_rd_addr];
            bank1 <= osd_rd_addr[9:7];
            // with OSD off the char is always checkable as 0
            exp2 <= en_m ? exp1 : 8'd0;
            ev2 <= ev1 || !en_m;
            hl2 <= en_m && ({5'b0, bank1} == hl_m);
        end
    end

    always_ff @(posedge clk) begin
        if (write_en && !addr[7]) begin
            shadow[{offset_m, addr[6:0]}] <= wr_data;
        end
    end

    // readback packing per register
    always_comb begin
        case (addr_q)
            REG_OSD_OFFSET: exp_rd = {5'b0, offset_m};
            REG_OSD_ENABLE: exp_rd = {7'b0, en_m};
            REG_HIGHLIGHT:  exp_rd = hl_m;
            REG_RECONF:     exp_rd = reconf_m;
            REG_CTRL_HI:    exp_rd = ctrl_q[11:4];
            REG_CTRL_LO:    exp_rd = {ctrl_q[3:0], 4'b0000};
            REG_SCAN_HI:    exp_rd = scan_hi_m;
            REG_SCAN_LO:    exp_rd = {scan_lo_m, 4'b0000};
            REG_RESET_CONF: exp_rd = rst_conf_m;
            default:        exp_rd = 8'h00;
        endcase
    end

    //////////////////////////////////////////////////
    // assertions
    //////////////////////////////////////////////////

    a_reset_vals: assert property (@(posedge clk) disable iff (!arst_n)
        first_q |-> (!enable_osd && !reset_dc && !reset_opt && video_mode == VM_1080P
                     && highlight_line == HIGHLIGHT_RST && bank_wr_en == 8'h00
                     && scan_intensity == SCAN_INTENSITY_RST))
    else begin
        err_count = err_count + 1;
        $error("reset values wrong after reset release at %0t", $time);
    end

    a_enable: assert property (@(posedge clk) disable iff (!arst_n)
        (we_q && addr_q == REG_OSD_ENABLE) |-> enable_osd == data_q[0])
    else begin
        err_count = err_count + 1;
        $error("Fail %0t enable_osd exp %0h got %0h", $time, $sampled(data_q[0]),
               $sampled(enable_osd));
    end

    a_highlight: assert property (@(posedge clk) disable iff (!arst_n)
        (we_q && addr_q == REG_HIGHLIGHT) |-> highlight_line == data_q)
    else begin
        err_count = err_count + 1;
        $error("Fail %0t highlight_line exp %0h got %0h", $time, $sampled(data_q),
               $sampled(highlight_line));
    end

    a_reset_conf: assert property (@(posedge clk) disable iff (!arst_n)
        (we_q && addr_q == REG_RESET_CONF) |-> reset_conf == data_q)
    else begin
        err_count = err_count + 1;
        $error("Fail %0t reset_conf exp %0h got %0h", $time, $sampled(data_q),
               $sampled(reset_conf));
    end

    a_scan_hi: assert property (@(posedge clk) disable iff (!arst_n)
        (we_q && addr_q == REG_SCAN_HI) |-> scan_intensity[8:1] == data_q)
    else begin
        err_count = err_count + 1;
        $error("Fail %0t scan_intensity[8:1] exp %0h got %0h", $time, $sampled(data_q),
               $sampled(scan_intensity[8:1]));
    end

    a_scan_lo: assert property (@(posedge clk) disable iff (!arst_n)
        (we_q && addr_q == REG_SCAN_LO) |-> {scan_intensity[0], scan_thickness,
                                              scan_oddeven, scan_active} == data_q[7:4])
    else begin
        err_count = err_count + 1;
        $error("Fail %0t scan flags exp %0h got %0h", $time, $sampled(data_q[7:4]),
               $sampled({scan_intensity[0], scan_thickness, scan_oddeven, scan_active}));
    end

    a_reconf_data: assert property (@(posedge clk) disable iff (!arst_n)
        (we_q && addr_q == REG_RECONF) |-> reconf_data == data_q)
    else begin
        err_count = err_count + 1;
        $error("Fail %0t reconf_data exp %0h got %0h", $time, $sampled(data_q),
               $sampled(reconf_data));
    end

    a_video_mode: assert property (@(posedge clk) disable iff (!arst_n)
        (we_q && addr_q == REG_RECONF) |-> video_mode == vm_m)
    else begin
        err_count = err_count + 1;
        $error("Fail %0t video_mode exp %0h got %0h", $time, $sampled(vm_m),
               $sampled(video_mode));
    end

    a_readback: assert property (@(posedge clk) disable iff (!arst_n)
        !we_q |-> rd_data == exp_rd)
    else begin
        err_count = err_count + 1;
        $error("Fail %0t rd_data exp %0h got %0h", $time, $sampled(exp_rd),
               $sampled(rd_data));
    end

    // high after a held write, low after an idle edge
    a_rst_dc: assert property (@(posedge clk) disable iff (!arst_n)
        (!we_q || addr_q == REG_RESET_DC) |-> reset_dc == we_q)
    else begin
        err_count = err_count + 1;
        $error("Fail %0t reset_dc exp %0h got %0h", $time, $sampled(we_q),
               $sampled(reset_dc));
    end

    a_rst_opt: assert property (@(posedge clk) disable iff (!arst_n)
        (!we_q || addr_q == REG_RESET_OPT) |-> reset_opt == we_q)
    else begin
        err_count = err_count + 1;
        $error("Fail %0t reset_opt exp %0h got %0h", $time, $sampled(we_q),
               $sampled(reset_opt));
    end

    a_bank_en: assert property (@(posedge clk) disable iff (!arst_n)
        bank_wr_en == exp_bank)
    else begin
        err_count = err_count + 1;
        $error("Fail %0t bank_wr_en exp %0h got %0h", $time, $sampled(exp_bank),
               $sampled(bank_wr_en));
    end

    a_char: assert property (@(posedge clk) disable iff (!arst_n)
        ev2 |-> osd_char == exp2)
    else begin
        err_count = err_count + 1;
        $error("Fail %0t osd_char exp %0h got %0h", $time, $sampled(exp2),
               $sampled(osd_char));
    end

    a_hl: assert property (@(posedge clk) disable iff (!arst_n)
        osd_highlight == hl2)
    else begin
        err_count = err_count + 1;
        $error("Fail %0t osd_highlight exp %0h got %0h", $time, $sampled(hl2),
               $sampled(osd_highlight));
    end

endmodule

bind osd_subsystem_top osd_subsystem_sva sva_i (.*);

// ==== rtl/osd_subsystem_top.sv ====
// top level of the OSD control side
// host strobe bus into the register file, eight character banks and the
// display reader, the display address carries bank index over column

`timescale 1ns/10ps

module osd_subsystem_top (
    input  logic                                     clk,
    input  logic                                     arst_n,
    // host bus
    input  logic [7:0]                               addr,
    input  logic [7:0]                               wr_data,
    input  logic                                     write_en,
    output logic [7:0]                               rd_data,
    input  logic [reg_map_pkg::CTRL_W-1:0]           ctrl_buttons,
    // control outputs
    output logic                                     enable_osd,
    output logic [7:0]                               highlight_line,
    output logic [7:0]                               reconf_data,
    output reg_map_pkg::video_mode_e                 video_mode,
    output logic [reg_map_pkg::SCAN_INTENSITY_W-1:0] scan_intensity,
    output logic                                     scan_thickness,
    output logic                                     scan_oddeven,
    output logic                                     scan_active,
    output logic                                     reset_dc,
    output logic                                     reset_opt,
    output logic [7:0]                               reset_conf,
    // display read path
    input  logic [osd_pkg::OSD_ADDR_W-1:0]           osd_rd_addr,
    output logic [7:0]                               osd_char,
    output logic                                     osd_highlight
);
    import osd_pkg::*;

    // register file to banks
    logic [OSD_BANKS-1:0] bank_wr_en;
    logic [OSD_COL_W-1:0] osd_wr_col;
    logic [7:0]           osd_wr_data;

    // banks to reader
    logic [7:0] bank_rd_data [OSD_BANKS];

    //////////////////////////////////////////////////
    // host registers
    //////////////////////////////////////////////////

    osd_reg_file u_reg_file (
        .clk            (clk),
        .arst_n         (arst_n),
        .addr           (addr),
        .wr_data        (wr_data),
        .write_en       (write_en),
        .ctrl_buttons   (ctrl_buttons),
        .rd_data        (rd_data),
        .enable_osd     (enable_osd),
        .highlight_line (highlight_line),
        .reconf_data    (reconf_data),
        .video_mode     (video_mode),
        .scan_intensity (scan_intensity),
        .scan_thickness (scan_thickness),
        .scan_oddeven   (scan_oddeven),
        .scan_active    (scan_active),
        .reset_dc       (reset_dc),
        .reset_opt      (reset_opt),
        .reset_conf     (reset_conf),
        .bank_wr_en     (bank_wr_en),
        .osd_wr_col     (osd_wr_col),
        .osd_wr_data    (osd_wr_data)
    );

    //////////////////////////////////////////////////
    // character banks, one per text line
    //////////////////////////////////////////////////

    // every bank reads the same column
    for (genvar k = 0; k < OSD_BANKS; k++) begin : gen_bank
        osd_ram_bank u_bank (
            .clk     (clk),
            .wr_en   (bank_wr_en[k]),
            .wr_col  (osd_wr_col),
            .wr_data (osd_wr_data),
            .rd_col  (osd_rd_addr[OSD_COL_W-1:0]),
            .rd_data (bank_rd_data[k])
        );
    end

    // bank index from the top of the display address
    osd_char_reader u_char_reader (
        .clk            (clk),
        .arst_n         (arst_n),
        .rd_bank        (osd_rd_addr[OSD_ADDR_W-1:OSD_COL_W]),
        .bank_rd_data   (bank_rd_data),
        .enable_osd     (enable_osd),
        .highlight_line (highlight_line),
        .osd_char       (osd_char),
        .osd_highlight  (osd_highlight)
    );

endmodule

// ==== rtl/osd_char_reader.sv ====
// display-side read path of the OSD character memory
// picks the addressed bank one cycle after the banks registered their bytes
// gates the character with the OSD enable and flags the highlighted line

`timescale 1ns/10ps

module osd_char_reader (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic [osd_pkg::OSD_BANK_W-1:0] rd_bank,
    input  logic [7:0]                     bank_rd_data [osd_pkg::OSD_BANKS],
    input  logic                           enable_osd,
    input  logic [7:0]                     highlight_line,
    output logic [7:0]                     osd_char,
    output logic                           osd_highlight
);
    import osd_pkg::*;

    // bank index lined up with bank read data
    logic [OSD_BANK_W-1:0] bank_q;

    // bank index widened for the highlight compare
    logic [7:0] line_idx;

    assign line_idx = {{(8-OSD_BANK_W){1'b0}}, bank_q};

    // stage 1
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bank_q <= '0;
        end else begin
            bank_q <= rd_bank;
        end
    end

    // stage 2
    // blank and no highlight while OSD is off
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            osd_char      <= '0;
            osd_highlight <= 1'b0;
        end else if (enable_osd) begin
            osd_char      <= bank_rd_data[bank_q];
            osd_highlight <= (line_idx == highlight_line);
        end else begin
            osd_char      <= '0;
            osd_highlight <= 1'b0;
        end
    end

endmodule

// ==== rtl/osd_ram_bank.sv ====
// one text line of OSD character memory
// write port from the register file, registered read port to the reader
// read-first, so a same-cycle read of the written cell sees the old byte

`timescale 1ns/10ps

module osd_ram_bank (
    input  logic                          clk,
    input  logic                          wr_en,
    input  logic [osd_pkg::OSD_COL_W-1:0] wr_col,
    input  logic [7:0]                    wr_data,
    input  logic [osd_pkg::OSD_COL_W-1:0] rd_col,
    output logic [7:0]                    rd_data
);
    import osd_pkg::*;

    // one byte per character cell
    logic [7:0] mem [OSD_BANK_DEPTH];

    // host side write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_col] <= wr_data;
        end
    end

    // display side read
    // free running, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_col];
    end

endmodule

// ==== rtl/osd_reg_file.sv ====
// host-side register file of the OSD add-on
// decodes the byte strobe bus, holds the control registers and returns
// registered readback, writes below 0x80 go to the character banks

`timescale 1ns/10ps

module osd_reg_file (
    input  logic                                     clk,
    input  logic                                     arst_n,
    input  logic [7:0]                               addr,
    input  logic [7:0]                               wr_data,
    input  logic                                     write_en,
    input  logic [reg_map_pkg::CTRL_W-1:0]           ctrl_buttons,
    output logic [7:0]                               rd_data,
    output logic                                     enable_osd,
    output logic [7:0]                               highlight_line,
    output logic [7:0]                               reconf_data,
    output reg_map_pkg::video_mode_e                 video_mode,
    output logic [reg_map_pkg::SCAN_INTENSITY_W-1:0] scan_intensity,
    output logic                                     scan_thickness,
    output logic                                     scan_oddeven,
    output logic                                     scan_active,
    output logic                                     reset_dc,
    output logic                                     reset_opt,
    output logic [7:0]                               reset_conf,
    output logic [osd_pkg::OSD_BANKS-1:0]            bank_wr_en,
    output logic [osd_pkg::OSD_COL_W-1:0]            osd_wr_col,
    output logic [7:0]                               osd_wr_data
);
    import reg_map_pkg::*;
    import osd_pkg::*;

    // host address seen as a register name
    reg_addr_e addr_dec;

    // character write on this edge
    logic char_wr;

    // bank picked for character writes
    logic [OSD_BANK_W-1:0] osd_offset;

    assign addr_dec = reg_addr_e'(addr);
    assign char_wr  = write_en && !addr[7];

    //////////////////////////////////////////////////
    // control register writes
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            osd_offset     <= '0;
            enable_osd     <= 1'b0;
            highlight_line <= HIGHLIGHT_RST;
            reconf_data    <= '0;
            video_mode     <= VM_1080P;
            scan_intensity <= SCAN_INTENSITY_RST;
            scan_thickness <= 1'b0;
            scan_oddeven   <= 1'b0;
            scan_active    <= 1'b0;
            reset_conf     <= '0;
        end else if (write_en) begin
            case (addr_dec)
                // bank offset for later character writes
                REG_OSD_OFFSET: osd_offset <= wr_data[OSD_BANK_W-1:0];
                REG_OSD_ENABLE: enable_osd <= wr_data[0];
                REG_HIGHLIGHT:  highlight_line <= wr_data;
                REG_RECONF: begin
                    // raw byte always kept
                    reconf_data <= wr_data;
                    // only codes 0..3 change the mode
                    case (wr_data[3:0])
                        4'd0:    video_mode <= VM_1080P;
                        4'd1:    video_mode <= VM_960P;
                        4'd2:    video_mode <= VM_480P;
                        4'd3:    video_mode <= VM_VGA;
                        default: video_mode <= video_mode;
                    endcase
                end
                // upper intensity bits
                REG_SCAN_HI: scan_intensity[SCAN_INTENSITY_W-1:1] <= wr_data;
                REG_SCAN_LO: begin
                    // intensity lsb and the three flags, low nibble ignored
                    scan_intensity[0] <= wr_data[7];
                    scan_thickness    <= wr_data[6];
                    scan_oddeven      <= wr_data[5];
                    scan_active       <= wr_data[4];
                end
                REG_RESET_CONF: reset_conf <= wr_data;
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // reset levels
    //////////////////////////////////////////////////

    // set by a write to its address
    // held while the strobe stays up, dropped on the first idle edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reset_dc  <= 1'b0;
            reset_opt <= 1'b0;
        end else if (!write_en) begin
            reset_dc  <= 1'b0;
            reset_opt <= 1'b0;
        end else begin
            if (addr_dec == REG_RESET_DC) begin
                reset_dc <= 1'b1;
            end
            if (addr_dec == REG_RESET_OPT) begin
                reset_opt <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // character write steering
    //////////////////////////////////////////////////

    // one-hot bank strobe, one cycle per write edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bank_wr_en <= '0;
        end else if (char_wr) begin
            bank_wr_en <= {{(OSD_BANKS-1){1'b0}}, 1'b1} << osd_offset;
        end else begin
            bank_wr_en <= '0;
        end
    end

    // column and byte travel with the strobe
    always_ff @(posedge clk) begin
        if (char_wr) begin
            osd_wr_col  <= addr[OSD_COL_W-1:0];
            osd_wr_data <= wr_data;
        end
    end

    //////////////////////////////////////////////////
    // readback
    //////////////////////////////////////////////////

    // shows register state from before the current edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_data <= '0;
        end else begin
            case (addr_dec)
                REG_OSD_OFFSET: rd_data <= {{(8-OSD_BANK_W){1'b0}}, osd_offset};
                REG_OSD_ENABLE: rd_data <= {7'b0, enable_osd};
                REG_HIGHLIGHT:  rd_data <= highlight_line;
                REG_RECONF:     rd_data <= reconf_data;
                // buttons, upper eight
                REG_CTRL_HI:    rd_data <= ctrl_buttons[CTRL_W-1:4];
                // buttons, lower four left aligned
                REG_CTRL_LO:    rd_data <= {ctrl_buttons[3:0], 4'b0000};
                REG_SCAN_HI:    rd_data <= scan_intensity[SCAN_INTENSITY_W-1:1];
                REG_SCAN_LO: begin
                    rd_data <= {scan_intensity[0], scan_thickness,
                                scan_oddeven, scan_active, 4'b0000};
                end
                REG_RESET_CONF: rd_data <= reset_conf;
                default:        rd_data <= '0;
            endcase
        end
    end

endmodule

// ==== rtl/osd_pkg.sv ====
// geometry of the OSD character memory
// shared by the register file, the banks, the reader and the top level
// one bank per text line, one byte per character

package osd_pkg;

    // text lines, one bank each
    localparam int OSD_BANKS = 8;

    // characters per line
    localparam int OSD_BANK_DEPTH = 128;

    // column address width inside a bank
    localparam int OSD_COL_W = 7;

    // bank index width
    localparam int OSD_BANK_W = 3;

    // display read address
    // bank index on top, column below
    localparam int OSD_ADDR_W = OSD_BANK_W + OSD_COL_W;

endpackage

// ==== rtl/reg_map_pkg.sv ====
// host register map for the OSD control block
// the register file, the top level and the testbench import this package
// holds address and video-mode encodings plus the register reset values

package reg_map_pkg;

    // host register addresses
    // anything below 0x80 is an OSD character write
    typedef enum logic [7:0] {
        REG_OSD_OFFSET = 8'h80,
        REG_OSD_ENABLE = 8'h81,
        REG_HIGHLIGHT  = 8'h82,
        REG_RECONF     = 8'h83,
        REG_CTRL_HI    = 8'h85,
        REG_CTRL_LO    = 8'h86,
        REG_SCAN_HI    = 8'h87,
        REG_SCAN_LO    = 8'h88,
        REG_RESET_DC   = 8'hF0,
        REG_RESET_OPT  = 8'hF1,
        REG_RESET_CONF = 8'hF2
    } reg_addr_e;

    // output video mode
    // picked by the low nibble of a reconf write
    typedef enum logic [1:0] {
        VM_1080P = 2'd0,
        VM_960P  = 2'd1,
        VM_480P  = 2'd2,
        VM_VGA   = 2'd3
    } video_mode_e;

    // scanline intensity, 9 bits split over two registers
    localparam int SCAN_INTENSITY_W = 9;
    localparam logic [SCAN_INTENSITY_W-1:0] SCAN_INTENSITY_RST = 9'h100;

    // no line highlighted out of reset
    localparam logic [7:0] HIGHLIGHT_RST = 8'd255;

    // controller button word width
    localparam int CTRL_W = 12;

endpackage
